// ==== logic/busPkg.sv ====
// Memory port subsystem: shared widths, depths and request/response payloads
package busPkg;

  // Requester ports: 0 instruction refill, 1 data refill/writeback, 2 table walker
  localparam int numMasters = 3;
  localparam int idW        = 2;

  localparam int addrW = 32;
  localparam int dataW = 32;
  localparam int maskW = dataW / 8;

  // Word memory, indexed by byte address bits 9:2
  localparam int memWords = 256;
  localparam int memIdxW  = $clog2(memWords);

  // Idle cycles between accept and response
  localparam int waitStates = 2;
  localparam int waitCntW   = $clog2(waitStates + 1);

  // Every request queue and the response queue
  localparam int fifoDepth = 4;
  localparam int fifoPtrW  = $clog2(fifoDepth);
  localparam int fifoCntW  = $clog2(fifoDepth + 1);

  typedef logic [idW-1:0]      portIdT;
  typedef logic [memIdxW-1:0]  memIdxT;
  typedef logic [waitCntW-1:0] waitCntT;
  typedef logic [fifoPtrW-1:0] fifoPtrT;
  typedef logic [fifoCntW-1:0] fifoCntT;

  // One word-wide access from a requester
  typedef struct packed {
    logic [addrW-1:0] addr;
    logic             write;
    logic [dataW-1:0] wData;
    logic [maskW-1:0] byteMask;
  } busReqT;

  // Request after arbitration, tagged with its source port
  typedef struct packed {
    portIdT id;
    busReqT req;
  } memReqT;

  // Read data, or zero for a write acknowledge
  typedef struct packed {
    portIdT           id;
    logic [dataW-1:0] rData;
  } memRspT;

endpackage

// ==== logic/syncFifo.sv ====
// Synchronous FIFO with valid/ready on both sides and a typed payload
`timescale 1ns/1ps

module syncFifo #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  payloadT          mem [busPkg::fifoDepth];
  busPkg::fifoPtrT  wrPtr;
  busPkg::fifoPtrT  rdPtr;
  busPkg::fifoCntT  count;
  logic             push;
  logic             pop;

  function automatic busPkg::fifoPtrT nextPtr(input busPkg::fifoPtrT ptr);
    if (ptr == busPkg::fifoPtrT'(busPkg::fifoDepth - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign outValid = (count != '0);
  // Full queue still takes a push when the head leaves this cycle
  assign inReady  = (count != busPkg::fifoCntT'(busPkg::fifoDepth)) || outReady;
  assign push     = inValid && inReady;
  assign pop      = outValid && outReady;
  assign outData  = mem[rdPtr];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inData;
  end

endmodule

// ==== logic/roundRobinArbiter.sv ====
// Round-robin arbiter picking one request queue head and tagging it with its port
`timescale 1ns/1ps

module roundRobinArbiter (
  input  logic                                      clk,
  input  logic                                      rstN,
  input  logic          [busPkg::numMasters-1:0]    headValid,
  output logic          [busPkg::numMasters-1:0]    headReady,
  input  busPkg::busReqT [busPkg::numMasters-1:0]   heads,
  output logic                                      memReqValid,
  input  logic                                      memReqReady,
  output busPkg::memReqT                            memReq
);

  // Port with highest priority this cycle
  busPkg::portIdT prioPtr;
  busPkg::portIdT winner;
  logic           found;
  logic           xfer;

  // Search upward from the pointer, wrapping at numMasters
  always_comb
  begin : pickWinner
    int idx;
    found  = 1'b0;
    winner = '0;
    for (int i = 0; i < busPkg::numMasters; i++)
    begin
      idx = int'(prioPtr) + i;
      if (idx >= busPkg::numMasters)
        idx = idx - busPkg::numMasters;
      if (!found && headValid[idx])
      begin
        found  = 1'b1;
        winner = busPkg::portIdT'(idx);
      end
    end
  end

  assign memReqValid = found;
  assign memReq.id   = winner;
  assign memReq.req  = heads[winner];
  assign xfer        = memReqValid && memReqReady;

  // Only the winning queue sees ready
  always_comb
  begin
    headReady = '0;
    for (int i = 0; i < busPkg::numMasters; i++)
    begin
      if (busPkg::portIdT'(i) == winner)
        headReady[i] = xfer;
    end
  end

  // Pointer moves to the port after the one just served
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      prioPtr <= '0;
    else if (xfer)
    begin
      if (winner == busPkg::portIdT'(busPkg::numMasters - 1))
        prioPtr <= '0;
      else
        prioPtr <= winner + 1'b1;
    end
  end

endmodule

// ==== logic/waitStateMemory.sv ====
// Word memory with byte-masked writes and fixed wait states per access
`timescale 1ns/1ps

module waitStateMemory (
  input  logic           clk,
  input  logic           rstN,
  input  logic           reqValid,
  output logic           reqReady,
  input  busPkg::memReqT req,
  output logic           rspValid,
  input  logic           rspReady,
  output busPkg::memRspT rsp
);

  typedef enum logic [1:0] {
    stIdle,
    stWait,
    stRespond
  } stateT;

  stateT                   state;
  busPkg::waitCntT         waitCnt;
  logic                    accept;
  logic                    lastWait;
  busPkg::memReqT          reqQ;
  busPkg::memIdxT          wordIdx;
  logic [busPkg::dataW-1:0] rdData;
  logic [busPkg::dataW-1:0] mem [busPkg::memWords];

  // One access at a time
  assign reqReady = (state == stIdle);
  assign accept   = reqValid && reqReady;
  assign lastWait = (state == stWait) &&
                    (waitCnt == busPkg::waitCntT'(busPkg::waitStates - 1));

  // Upper address bits alias onto the same word
  assign wordIdx  = reqQ.req.addr[busPkg::memIdxW+1:2];

  assign rspValid  = (state == stRespond);
  assign rsp.id    = reqQ.id;
  assign rsp.rData = rdData;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state   <= stIdle;
      waitCnt <= '0;
    end
    else
    begin
      case (state)
        stIdle:
        begin
          if (accept)
          begin
            state   <= stWait;
            waitCnt <= '0;
          end
        end
        stWait:
        begin
          if (lastWait)
            state <= stRespond;
          else
            waitCnt <= waitCnt + 1'b1;
        end
        stRespond:
        begin
          // Held until the response queue takes it
          if (rspValid && rspReady)
            state <= stIdle;
        end
        default:
          state <= stIdle;
      endcase
    end
  end

  // Array access at the end of the wait period
  always_ff @(posedge clk)
  begin
    if (accept)
      reqQ <= req;
    if (lastWait)
    begin
      // Reads return the word before the access, writes return zero
      rdData <= reqQ.req.write ? '0 : mem[wordIdx];
      if (reqQ.req.write)
      begin
        for (int b = 0; b < busPkg::maskW; b++)
        begin
          if (reqQ.req.byteMask[b])
            mem[wordIdx][8*b +: 8] <= reqQ.req.wData[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== logic/responseRouter.sv ====
// Response router steering each tagged response to its requester port
`timescale 1ns/1ps

module responseRouter (
  input  logic                                          inValid,
  output logic                                          inReady,
  input  busPkg::memRspT                                inRsp,
  output logic [busPkg::numMasters-1:0]                 rspValid,
  input  logic [busPkg::numMasters-1:0]                 rspReady,
  output logic [busPkg::numMasters-1:0][busPkg::dataW-1:0] rspData
);

  // One-hot decode of the tag
  logic [busPkg::numMasters-1:0] portSel;

  always_comb
  begin
    portSel = '0;
    for (int p = 0; p < busPkg::numMasters; p++)
    begin
      if (inRsp.id == busPkg::portIdT'(p))
        portSel[p] = 1'b1;
    end
  end

  assign rspValid = inValid ? portSel : '0;

  // Head waits on its own port only, stalling everything behind it
  assign inReady = |(portSel & rspReady);

  // Data fans out to every port, valid picks the owner
  always_comb
  begin
    for (int p = 0; p < busPkg::numMasters; p++)
      rspData[p] = inRsp.rData;
  end

endmodule

// ==== logic/memSubsystem.sv ====
// Shared memory port: per-port request queues, arbiter, memory and response routing
`timescale 1ns/1ps

module memSubsystem (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  logic           [busPkg::numMasters-1:0]          reqValid,
  output logic           [busPkg::numMasters-1:0]          reqReady,
  input  busPkg::busReqT [busPkg::numMasters-1:0]          req,
  output logic           [busPkg::numMasters-1:0]          rspValid,
  input  logic           [busPkg::numMasters-1:0]          rspReady,
  output logic [busPkg::numMasters-1:0][busPkg::dataW-1:0] rspData
);

  // Queue heads
  logic           [busPkg::numMasters-1:0] headValid;
  logic           [busPkg::numMasters-1:0] headReady;
  busPkg::busReqT [busPkg::numMasters-1:0] heads;

  // Arbiter to memory
  logic           memReqValid;
  logic           memReqReady;
  busPkg::memReqT memReq;

  // Memory to response queue
  logic           memRspValid;
  logic           memRspReady;
  busPkg::memRspT memRsp;

  // Response queue head
  logic           rspqValid;
  logic           rspqReady;
  busPkg::memRspT rspqHead;

  for (genvar p = 0; p < busPkg::numMasters; p++)
  begin : gReqQueue
    syncFifo #(
      .payloadT (busPkg::busReqT)
    ) reqQueue (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (reqValid[p]),
      .inReady  (reqReady[p]),
      .inData   (req[p]),
      .outValid (headValid[p]),
      .outReady (headReady[p]),
      .outData  (heads[p])
    );
  end

  roundRobinArbiter arbiter (
    .clk         (clk),
    .rstN        (rstN),
    .headValid   (headValid),
    .headReady   (headReady),
    .heads       (heads),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReq      (memReq)
  );

  waitStateMemory memory (
    .clk      (clk),
    .rstN     (rstN),
    .reqValid (memReqValid),
    .reqReady (memReqReady),
    .req      (memReq),
    .rspValid (memRspValid),
    .rspReady (memRspReady),
    .rsp      (memRsp)
  );

  syncFifo #(
    .payloadT (busPkg::memRspT)
  ) rspQueue (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (memRspValid),
    .inReady  (memRspReady),
    .inData   (memRsp),
    .outValid (rspqValid),
    .outReady (rspqReady),
    .outData  (rspqHead)
  );

  responseRouter router (
    .inValid  (rspqValid),
    .inReady  (rspqReady),
    .inRsp    (rspqHead),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData)
  );

endmodule

// ==== dv/memSubsystemTb.sv ====
// Memory subsystem testbench replaying golden traffic on three ports and checking responses
`timescale 1ns/1ps

module memSubsystemTb;

  localparam int nCols    = 7;
  localparam int maxLines = 64;
  localparam int maxWait  = 200;
  localparam logic [31:0] endMark = 32'hffff_ffff;

  logic                                             clk;
  logic                                             rstN;
  logic           [busPkg::numMasters-1:0]          reqValid;
  logic           [busPkg::numMasters-1:0]          reqReady;
  busPkg::busReqT [busPkg::numMasters-1:0]          req;
  logic           [busPkg::numMasters-1:0]          rspValid;
  logic           [busPkg::numMasters-1:0]          rspReady;
  logic [busPkg::numMasters-1:0][busPkg::dataW-1:0] rspData;

  // Golden file flattened, seven words per transaction line
  logic [31:0]              gold [nCols*maxLines];
  logic [busPkg::dataW-1:0] model [busPkg::memWords];
  int                       sendQ [busPkg::numMasters][$];
  logic [busPkg::dataW-1:0] expQ [busPkg::numMasters][$];
  int                       ordRemain [busPkg::numMasters];
  busPkg::portIdT           grantPtr;
  logic                     orderMode;
  logic                     stallMode;
  logic [31:0]              lcgState;
  int                       dataErrs;
  int                       orderErrs;
  int                       timeoutErrs;

  memSubsystem i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // First port from the pointer that still owes a response
  function automatic busPkg::portIdT nextOrderPort();
    int p;
    p = int'(grantPtr);
    for (int i = 0; i < busPkg::numMasters; i++)
    begin
      if (ordRemain[p] > 0)
        return busPkg::portIdT'(p);
      p = (p + 1) % busPkg::numMasters;
    end
    return grantPtr;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < busPkg::numMasters; p++)
      n += expQ[p].size();
    return n;
  endfunction

  task automatic checkRsp(input int port, input logic [busPkg::dataW-1:0] got,
                          input logic [busPkg::dataW-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: port %0d response data %h, expected %h", $time, port, got, exp);
      dataErrs++;
    end
  endtask

  task automatic checkOrder(input busPkg::portIdT got, input busPkg::portIdT exp);
    if (got !== exp)
    begin
      $display("ERR %0t: response on port %0d, expected port %0d", $time, got, exp);
      orderErrs++;
    end
  endtask

  task automatic checkFlags(input string what, input logic [busPkg::numMasters-1:0] got,
                            input logic [busPkg::numMasters-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s %b, expected %b", $time, what, got, exp);
      dataErrs++;
    end
  endtask

  // Apply one golden line to the shadow memory and queue it for its port
  task automatic queueLine(input int ln);
    int          p;
    int          idx;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [31:0] expData;
    p     = int'(gold[ln*nCols]);
    addr  = gold[ln*nCols+2];
    wData = gold[ln*nCols+3];
    // Word index from byte address bits 9:2
    idx   = int'(addr[9:2]);
    if (gold[ln*nCols+1][0])
    begin
      for (int b = 0; b < busPkg::maskW; b++)
      begin
        if (gold[ln*nCols+4][b])
          model[idx][8*b +: 8] = wData[8*b +: 8];
      end
      expData = '0;
    end
    else
      expData = model[idx];
    if (expData !== gold[ln*nCols+5])
    begin
      $display("Golden line %0d expects %h but the byte-merge model gives %h",
               ln, gold[ln*nCols+5], expData);
      dataErrs++;
    end
    sendQ[p].push_back(ln);
    expQ[p].push_back(expData);
    if (orderMode)
      ordRemain[p]++;
  endtask

  task automatic driveLine(input int p, input int ln);
    int waited;
    waited             = 0;
    reqValid[p]        = 1'b1;
    req[p].addr        = gold[ln*nCols+2];
    req[p].write       = gold[ln*nCols+1][0];
    req[p].wData       = gold[ln*nCols+3];
    req[p].byteMask    = gold[ln*nCols+4][busPkg::maskW-1:0];
    @(negedge clk);
    while (!reqReady[p] && waited < maxWait)
    begin
      waited++;
      @(negedge clk);
    end
    if (!reqReady[p])
    begin
      $display("Port %0d stalled waiting for reqReady on golden line %0d", p, ln);
      timeoutErrs++;
    end
    @(posedge clk);
    #2;
    reqValid[p] = 1'b0;
  endtask

  task automatic drivePort(input int p);
    int ln;
    while (sendQ[p].size() > 0 && timeoutErrs == 0)
    begin
      ln = sendQ[p].pop_front();
      driveLine(p, ln);
    end
  endtask

  task automatic waitDrained();
    int waited;
    waited = 0;
    while (pending() > 0 && waited < maxWait)
    begin
      @(posedge clk);
      waited++;
    end
    for (int p = 0; p < busPkg::numMasters; p++)
    begin
      if (expQ[p].size() > 0)
      begin
        $display("Port %0d stalled waiting for rspValid, %0d responses missing",
                 p, expQ[p].size());
        timeoutErrs++;
      end
    end
  endtask

  // Response ready drops at random in stall groups
  always @(posedge clk)
  begin
    #2;
    if (stallMode)
    begin
      lcgState = lcgNext(lcgState);
      for (int p = 0; p < busPkg::numMasters; p++)
        rspReady[p] = lcgState[31-p] | lcgState[27-p];
    end
    else
      rspReady = '1;
  end

  // Handshake sampled mid-cycle before the transfer edge
  always @(negedge clk)
  begin : respMonitor
    busPkg::portIdT expPort;
    if (rstN)
    begin
      for (int p = 0; p < busPkg::numMasters; p++)
      begin
        if (rspValid[p] && rspReady[p])
        begin
          if (expQ[p].size() == 0)
          begin
            $display("ERR %0t: unexpected response on port %0d", $time, p);
            dataErrs++;
          end
          else
            checkRsp(p, rspData[p], expQ[p].pop_front());
          if (orderMode)
          begin
            expPort = nextOrderPort();
            checkOrder(busPkg::portIdT'(p), expPort);
            if (ordRemain[p] > 0)
              ordRemain[p]--;
          end
          grantPtr = busPkg::portIdT'((p + 1) % busPkg::numMasters);
        end
      end
    end
  end

  initial
  begin : mainSeq
    int          ln;
    logic [31:0] mark;
    clk         = 1'b0;
    rstN        = 1'b0;
    reqValid    = '0;
    req         = '0;
    rspReady    = '0;
    orderMode   = 1'b0;
    stallMode   = 1'b0;
    lcgState    = 32'h9b33_6d1f;
    grantPtr    = '0;
    dataErrs    = 0;
    orderErrs   = 0;
    timeoutErrs = 0;
    ordRemain   = '{default: 0};
    for (int i = 0; i < nCols*maxLines; i++)
      gold[i] = endMark;
    $readmemh("dv/memGolden.txt", gold);
    if (gold[0] === endMark)
    begin
      $display("Golden file dv/memGolden.txt holds no transactions");
      dataErrs++;
    end

    repeat (16) @(posedge clk);
    #2;
    rstN = 1'b1;
    @(negedge clk);
    checkFlags("reqReady after reset", reqReady, '1);
    checkFlags("rspValid after reset", rspValid, '0);

    // One group per run of equal marks
    ln = 0;
    while (ln < maxLines && gold[ln*nCols] != endMark && timeoutErrs == 0)
    begin
      mark      = gold[ln*nCols+6];
      orderMode = mark[6];
      stallMode = mark[7];
      ordRemain = '{default: 0};
      while (ln < maxLines && gold[ln*nCols+6] == mark)
      begin
        queueLine(ln);
        ln++;
      end
      @(posedge clk);
      #2;
      fork
        drivePort(0);
        drivePort(1);
        drivePort(2);
      join
      waitDrained();
      repeat (4) @(posedge clk);
    end
    // Idle tail to catch duplicated responses
    stallMode = 1'b0;
    repeat (20) @(posedge clk);

    $display("Errors: data %0d, order %0d, timeout %0d", dataErrs, orderErrs, timeoutErrs);
    if (dataErrs + orderErrs + timeoutErrs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== Bender.yml ====
package:
  name: memSubsystem

sources:
  - logic/busPkg.sv
  - logic/syncFifo.sv
  - logic/roundRobinArbiter.sv
  - logic/waitStateMemory.sv
  - logic/responseRouter.sv
  - logic/memSubsystem.sv
  - target: simulation
    files:
      - dv/memSubsystemTb.sv

// ==== verilog.f ====
logic/busPkg.sv
logic/syncFifo.sv
logic/roundRobinArbiter.sv
logic/waitStateMemory.sv
logic/responseRouter.sv
logic/memSubsystem.sv
dv/memSubsystemTb.sv

// ==== dv/memGolden.txt ====
// port write addr wdata mask expected mark
// mark: group id in bits 5:0, bit 6 checks round-robin order, bit 7 adds rspReady stalls
0 1 00000000 11111111 f 00000000 41
1 1 00000100 33333333 f 00000000 41
2 1 00000200 55555555 f 00000000 41
0 1 00000004 22222222 f 00000000 41
1 1 00000104 44444444 f 00000000 41
2 1 00000204 66666666 f 00000000 41
0 0 00000000 00000000 0 11111111 02
1 0 00000100 00000000 0 33333333 02
2 0 00000204 00000000 0 66666666 02
0 0 00000004 00000000 0 22222222 02
1 1 00000100 aabbccdd 3 00000000 03
2 1 00000200 00ff0000 4 00000000 03
0 1 00000004 99000000 8 00000000 03
1 0 00000100 00000000 0 3333ccdd 04
2 0 00000200 00000000 0 55ff5555 04
0 0 00000004 00000000 0 99222222 04
2 1 00000c08 0badf00d f 00000000 05
0 0 fffff008 00000000 0 0badf00d 06
1 0 80000408 00000000 0 0badf00d 06
0 0 00000000 00000000 0 11111111 87
1 0 00000200 00000000 0 55ff5555 87
2 0 00000204 00000000 0 66666666 87
0 1 00000010 12345678 f 00000000 87
1 1 00000110 cafef00d f 00000000 87
2 1 00000210 deadbeef f 00000000 87
0 0 00000104 00000000 0 44444444 87
1 0 00000004 00000000 0 99222222 87
2 0 00000100 00000000 0 3333ccdd 87
0 1 00000014 a5a5a5a5 f 00000000 87
1 1 00000114 0f0f0f0f f 00000000 87
2 1 00000214 13579bdf f 00000000 87
0 0 00000210 00000000 0 deadbeef 88
1 0 00000010 00000000 0 12345678 88
2 0 00000114 00000000 0 0f0f0f0f 88
0 0 00000110 00000000 0 cafef00d 88
1 0 00000214 00000000 0 13579bdf 88
2 0 00000014 00000000 0 a5a5a5a5 88
2 1 00000010 0000ff00 2 00000000 89
0 0 00000810 00000000 0 1234ff78 0a
1 0 fffffc10 00000000 0 1234ff78 0a
